/* source/line_code_pkg.sv */
`default_nettype none

package line_code_pkg;

    localparam int byte_width = 8;

    // One lane character, data byte or code group.
    typedef logic [byte_width-1:0] lane_byte_t;

    // Host control characters, XGMII encoding.
    localparam lane_byte_t char_idle  = 8'h07;
    localparam lane_byte_t char_start = 8'hfb;
    localparam lane_byte_t char_term  = 8'hfd;
    localparam lane_byte_t char_error = 8'hfe;

    // Idle code groups, before 8b/10b.
    localparam lane_byte_t code_k = 8'hbc;  // K28.5
    localparam lane_byte_t code_a = 8'h7c;  // K28.3
    localparam lane_byte_t code_r = 8'h1c;  // K28.0

    // Value shown on the lane before any byte is sampled.
    localparam lane_byte_t code_none = 8'h00;

endpackage

`default_nettype wire

/* source/idle_seq_pkg.sv */
`default_nettype none

package idle_seq_pkg;

    localparam int lfsr_width  = 7;
    localparam int count_width = 5;

    // Pseudo-random register, x^7 + x^6 + 1.
    typedef logic [lfsr_width-1:0] lfsr_t;

    // Countdown between A characters.
    typedef logic [count_width-1:0] count_t;

    localparam lfsr_t  lfsr_seed  = 7'h02;
    localparam count_t count_zero = 5'd0;

endpackage

`default_nettype wire

/* source/lane_char_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface lane_char_if;

    // Character byte, or char_error for an unknown control byte.
    line_code_pkg::lane_byte_t char_byte;
    logic                      ctrl;
    logic                      idle;
    logic                      valid;

    modport src (
        output char_byte,
        output ctrl,
        output idle,
        output valid
    );

    modport sink (
        input char_byte,
        input ctrl,
        input idle,
        input valid
    );

endinterface

`default_nettype wire

/* source/tx_char_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module tx_char_decode (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      clk_en,
    input  line_code_pkg::lane_byte_t txd,
    input  logic                      txc,
    lane_char_if.src                  char_out
);

    line_code_pkg::lane_byte_t next_byte;
    logic                      next_ctrl;
    logic                      next_idle;

    // Classify the host byte.
    always_comb begin
        next_byte = txd;
        next_ctrl = txc;
        next_idle = 1'b0;
        if (txc) begin
            case (txd)
                line_code_pkg::char_start,
                line_code_pkg::char_term,
                line_code_pkg::char_error: begin
                    next_byte = txd;
                end
                line_code_pkg::char_idle: begin
                    next_idle = 1'b1;
                end
                default: begin
                    next_byte = line_code_pkg::char_error;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            char_out.valid <= 1'b0;
            char_out.idle  <= 1'b0;
        end else if (clk_en) begin
            char_out.valid <= 1'b1;
            char_out.idle  <= next_idle;
        end
    end

    // Payload.
    always_ff @(posedge clk) begin
        if (clk_en) begin
            char_out.char_byte <= next_byte;
            char_out.ctrl      <= next_ctrl;
        end
    end

endmodule

`default_nettype wire

/* source/idle_seq_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module idle_seq_gen (
    input  logic clk,
    input  logic rst,
    input  logic clk_en,
    input  logic send_idle,
    output logic send_k,
    output logic send_a,
    output logic send_r
);

    idle_seq_pkg::lfsr_t  lfsr;
    idle_seq_pkg::count_t down_cnt;
    logic                 idle_dly;
    logic                 cnt_zero;
    logic                 rand_bit;

    assign cnt_zero = (down_cnt == idle_seq_pkg::count_zero);
    assign rand_bit = lfsr[0];

    // Runs on every enabled cycle, idle or not.
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= idle_seq_pkg::lfsr_seed;
        end else if (clk_en) begin
            lfsr <= {lfsr[6] ^ lfsr[0], lfsr[6:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            down_cnt <= idle_seq_pkg::count_zero;
        end else if (clk_en) begin
            if (cnt_zero) begin
                down_cnt <= lfsr[4:0];
            end else begin
                down_cnt <= down_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            idle_dly <= 1'b0;
        end else if (clk_en) begin
            idle_dly <= send_idle;
        end
    end

    // One-hot choice per idle character; all low otherwise.
    always_ff @(posedge clk) begin
        if (rst) begin
            send_k <= 1'b0;
            send_a <= 1'b0;
            send_r <= 1'b0;
        end else if (clk_en) begin
            send_k <= send_idle & (!idle_dly | (!cnt_zero & rand_bit));
            send_a <= send_idle & idle_dly & cnt_zero;
            send_r <= send_idle & idle_dly & !cnt_zero & !rand_bit;
        end
    end

endmodule

`default_nettype wire

/* source/tx_code_select.sv */
`timescale 1ns/100ps
`default_nettype none

module tx_code_select (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       clk_en,
    lane_char_if.sink                  char_in,
    input  logic                       send_k,
    input  logic                       send_a,
    input  logic                       send_r,
    output line_code_pkg::lane_byte_t  tx_code,
    output logic                       tx_k
);

    line_code_pkg::lane_byte_t stage_byte;
    logic                      stage_ctrl;
    logic                      stage_valid;
    line_code_pkg::lane_byte_t next_code;
    logic                      next_k;

    // Hold one character to meet the idle choice.
    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid <= 1'b0;
        end else if (clk_en) begin
            stage_valid <= char_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (clk_en) begin
            stage_byte <= char_in.char_byte;
            stage_ctrl <= char_in.ctrl;
        end
    end

    always_comb begin
        next_code = stage_byte;
        next_k    = stage_ctrl;
        if (!stage_valid) begin
            next_code = line_code_pkg::code_none;
            next_k    = 1'b0;
        end else if (send_k) begin
            next_code = line_code_pkg::code_k;
            next_k    = 1'b1;
        end else if (send_a) begin
            next_code = line_code_pkg::code_a;
            next_k    = 1'b1;
        end else if (send_r) begin
            next_code = line_code_pkg::code_r;
            next_k    = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_code <= line_code_pkg::code_none;
            tx_k    <= 1'b0;
        end else if (clk_en) begin
            tx_code <= next_code;
            tx_k    <= next_k;
        end
    end

endmodule

`default_nettype wire

/* source/xaui_tx_lane.sv */
`timescale 1ns/100ps
`default_nettype none

module xaui_tx_lane (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      clk_en,
    input  logic                      txc,
    input  line_code_pkg::lane_byte_t txd,
    output line_code_pkg::lane_byte_t tx_code,
    output logic                      tx_k
);

    logic send_k;
    logic send_a;
    logic send_r;

    lane_char_if dec_if ();

    tx_char_decode u_decode (
        .clk      (clk),
        .rst      (rst),
        .clk_en   (clk_en),
        .txd      (txd),
        .txc      (txc),
        .char_out (dec_if.src)
    );

    // Idle bit comes registered from decode.
    idle_seq_gen u_idle (
        .clk       (clk),
        .rst       (rst),
        .clk_en    (clk_en),
        .send_idle (dec_if.idle),
        .send_k    (send_k),
        .send_a    (send_a),
        .send_r    (send_r)
    );

    tx_code_select u_select (
        .clk     (clk),
        .rst     (rst),
        .clk_en  (clk_en),
        .char_in (dec_if.sink),
        .send_k  (send_k),
        .send_a  (send_a),
        .send_r  (send_r),
        .tx_code (tx_code),
        .tx_k    (tx_k)
    );

endmodule

`default_nettype wire

/* testbench/tb_xaui_tx_lane.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_xaui_tx_lane;

    typedef struct packed {
        logic [7:0] txd;
        logic       txc;
        logic [7:0] count;
        logic [7:0] exp_code;
        logic       exp_k;
        logic       use_model;
        logic       rand_data;
        logic       rand_en;
        logic [2:0] test_id;
    } stim_entry_t;

    logic                      clk = 1'b0;
    logic                      rst;
    logic                      clk_en;
    logic                      txc;
    line_code_pkg::lane_byte_t txd;
    line_code_pkg::lane_byte_t tx_code;
    logic                      tx_k;

    stim_entry_t               stim_table [0:31];
    int                        num_entries = 0;
    string                     test_names [0:4];

    // Idle model state.
    idle_seq_pkg::lfsr_t       m_lfsr;
    idle_seq_pkg::count_t      m_cnt;
    logic                      m_prev_idle;

    line_code_pkg::lane_byte_t exp_code_q [$];
    logic                      exp_k_q [$];
    line_code_pkg::lane_byte_t cur_code;
    logic                      cur_k;
    line_code_pkg::lane_byte_t pend_code;
    logic                      pend_k;
    logic                      pend_use;
    logic                      pend_idle;

    int                        checks;
    int                        errors;
    int                        test_errors;
    int                        en_edges;
    logic [31:0]               rng;
    logic                      timed_out;

    xaui_tx_lane dut0 (
        .clk     (clk),
        .rst     (rst),
        .clk_en  (clk_en),
        .txc     (txc),
        .txd     (txd),
        .tx_code (tx_code),
        .tx_k    (tx_k)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // One enabled edge of the idle rule; code is the choice for an idle byte.
    task automatic model_step(input logic is_idle, output line_code_pkg::lane_byte_t code);
        idle_seq_pkg::lfsr_t old_lfsr;
        old_lfsr = m_lfsr;
        m_lfsr = {old_lfsr[6] ^ old_lfsr[0], old_lfsr[6:1]};
        if (m_cnt == 5'd0) begin
            m_cnt = old_lfsr[4:0];
        end else begin
            m_cnt = m_cnt - 5'd1;
        end
        if (!m_prev_idle) begin
            code = line_code_pkg::code_k;
        end else if (m_cnt == 5'd0) begin
            code = line_code_pkg::code_a;
        end else if (m_lfsr[0]) begin
            code = line_code_pkg::code_k;
        end else begin
            code = line_code_pkg::code_r;
        end
        m_prev_idle = is_idle;
    endtask

    task automatic check_outputs();
        checks = checks + 1;
        if (tx_code !== cur_code) begin
            errors = errors + 1;
            test_errors = test_errors + 1;
            $display("error: tx_code expected %h actual %h", cur_code, tx_code);
        end
        if (tx_k !== cur_k) begin
            errors = errors + 1;
            test_errors = test_errors + 1;
            $display("error: tx_k expected %h actual %h", cur_k, tx_k);
        end
    endtask

    // Settle the byte sampled at this edge, drive the next one, check at negedge.
    task automatic run_cycle(input line_code_pkg::lane_byte_t d, input logic c, input logic en,
                             input line_code_pkg::lane_byte_t e_code, input logic e_k,
                             input logic use_model);
        line_code_pkg::lane_byte_t idle_code;
        @(posedge clk);
        if (clk_en) begin
            en_edges = en_edges + 1;
            model_step(pend_idle, idle_code);
            exp_code_q.push_back(pend_use ? idle_code : pend_code);
            exp_k_q.push_back(pend_use ? 1'b1 : pend_k);
            if (exp_code_q.size() == 3) begin
                cur_code = exp_code_q.pop_front();
                cur_k = exp_k_q.pop_front();
            end
        end
        txd <= d;
        txc <= c;
        clk_en <= en;
        pend_code = e_code;
        pend_k = e_k;
        pend_use = use_model;
        pend_idle = c && (d == 8'h07);
        @(negedge clk);
        check_outputs();
    endtask

    task automatic add_entry(input logic [7:0] d, input logic c, input logic [7:0] n,
                             input logic [7:0] e_code, input logic e_k, input logic use_m,
                             input logic r_data, input logic r_en, input logic [2:0] id);
        stim_table[num_entries] = {d, c, n, e_code, e_k, use_m, r_data, r_en, id};
        num_entries = num_entries + 1;
    endtask

    task automatic build_table();
        add_entry(8'h00, 1'b0, 8'd24, 8'h00, 1'b0, 1'b0, 1'b1, 1'b0, 3'd1);
        add_entry(8'hfb, 1'b1, 8'd2, 8'hfb, 1'b1, 1'b0, 1'b0, 1'b0, 3'd2);
        add_entry(8'hfd, 1'b1, 8'd2, 8'hfd, 1'b1, 1'b0, 1'b0, 1'b0, 3'd2);
        add_entry(8'hfe, 1'b1, 8'd2, 8'hfe, 1'b1, 1'b0, 1'b0, 1'b0, 3'd2);
        add_entry(8'h1c, 1'b1, 8'd2, 8'hfe, 1'b1, 1'b0, 1'b0, 1'b0, 3'd2);
        add_entry(8'h5a, 1'b1, 8'd2, 8'hfe, 1'b1, 1'b0, 1'b0, 1'b0, 3'd2);
        add_entry(8'h9c, 1'b1, 8'd1, 8'hfe, 1'b1, 1'b0, 1'b0, 1'b0, 3'd2);
        add_entry(8'h07, 1'b0, 8'd2, 8'h07, 1'b0, 1'b0, 1'b0, 1'b0, 3'd2);
        // Idle runs broken by short frames.
        add_entry(8'h07, 1'b1, 8'd40, 8'h00, 1'b0, 1'b1, 1'b0, 1'b0, 3'd3);
        add_entry(8'hfb, 1'b1, 8'd1, 8'hfb, 1'b1, 1'b0, 1'b0, 1'b0, 3'd3);
        add_entry(8'h00, 1'b0, 8'd6, 8'h00, 1'b0, 1'b0, 1'b1, 1'b0, 3'd3);
        add_entry(8'hfd, 1'b1, 8'd1, 8'hfd, 1'b1, 1'b0, 1'b0, 1'b0, 3'd3);
        add_entry(8'h07, 1'b1, 8'd35, 8'h00, 1'b0, 1'b1, 1'b0, 1'b0, 3'd3);
        add_entry(8'hfe, 1'b1, 8'd1, 8'hfe, 1'b1, 1'b0, 1'b0, 1'b0, 3'd3);
        add_entry(8'h07, 1'b1, 8'd60, 8'h00, 1'b0, 1'b1, 1'b0, 1'b0, 3'd3);
        // Random clock enable.
        add_entry(8'h07, 1'b1, 8'd40, 8'h00, 1'b0, 1'b1, 1'b0, 1'b1, 3'd4);
        add_entry(8'hfb, 1'b1, 8'd1, 8'hfb, 1'b1, 1'b0, 1'b0, 1'b1, 3'd4);
        add_entry(8'h00, 1'b0, 8'd8, 8'h00, 1'b0, 1'b0, 1'b1, 1'b1, 3'd4);
        add_entry(8'hfd, 1'b1, 8'd1, 8'hfd, 1'b1, 1'b0, 1'b0, 1'b1, 3'd4);
        add_entry(8'h07, 1'b1, 8'd40, 8'h00, 1'b0, 1'b1, 1'b0, 1'b1, 3'd4);
        add_entry(8'h5a, 1'b1, 8'd1, 8'hfe, 1'b1, 1'b0, 1'b0, 1'b1, 3'd4);
        add_entry(8'h07, 1'b1, 8'd24, 8'h00, 1'b0, 1'b1, 1'b0, 1'b1, 3'd4);
    endtask

    initial begin
        int          i;
        int          done;
        int          cycles;
        logic        en;
        logic [7:0]  d;
        stim_entry_t ent;
        rst = 1'b1;
        clk_en = 1'b0;
        txc = 1'b0;
        txd = 8'h00;
        m_lfsr = idle_seq_pkg::lfsr_seed;
        m_cnt = 5'd0;
        m_prev_idle = 1'b0;
        cur_code = 8'h00;
        cur_k = 1'b0;
        pend_code = 8'h00;
        pend_k = 1'b0;
        pend_use = 1'b0;
        pend_idle = 1'b0;
        checks = 0;
        errors = 0;
        test_errors = 0;
        en_edges = 0;
        timed_out = 1'b0;
        rng = 32'h31b9_1f10;
        test_names = '{"reset", "data", "delimiters", "idle sequence", "clock enable"};
        build_table();
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // First byte must surface on the third enabled edge.
        cycles = 0;
        run_cycle(8'h3c, 1'b0, 1'b1, 8'h3c, 1'b0, 1'b0);
        while (tx_code !== 8'h3c && !timed_out) begin
            cycles = cycles + 1;
            if (cycles > 16) begin
                $display("timeout: first byte never reached tx_code");
                timed_out = 1'b1;
            end else begin
                run_cycle(8'h3c, 1'b0, 1'b1, 8'h3c, 1'b0, 1'b0);
            end
        end
        if (!timed_out && en_edges != 3) begin
            errors = errors + 1;
            test_errors = test_errors + 1;
            $display("first byte took %0d enabled edges instead of 3", en_edges);
        end
        $display("test 0 %s finished, %0d errors", test_names[0], test_errors);
        test_errors = 0;

        for (i = 0; i < num_entries && !timed_out; i = i + 1) begin
            ent = stim_table[i];
            done = 0;
            cycles = 0;
            while (done < ent.count && !timed_out) begin
                rng = next_random(rng);
                en = ent.rand_en ? (rng[9:8] != 2'b00) : 1'b1;
                d = ent.rand_data ? rng[7:0] : ent.txd;
                if (ent.rand_data) begin
                    run_cycle(d, ent.txc, en, d, 1'b0, 1'b0);
                end else begin
                    run_cycle(d, ent.txc, en, ent.exp_code, ent.exp_k, ent.use_model);
                end
                if (en) begin
                    done = done + 1;
                end
                cycles = cycles + 1;
                if (cycles > 8 * ent.count + 16) begin
                    $display("timeout: table entry %0d did not finish", i);
                    timed_out = 1'b1;
                end
            end
            if (i == num_entries - 1 || stim_table[i + 1].test_id != ent.test_id) begin
                $display("test %0d %s finished, %0d errors", ent.test_id,
                         test_names[ent.test_id], test_errors);
                test_errors = 0;
            end
        end

        $display("checks %0d, errors %0d, timeout %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
source/line_code_pkg.sv
source/idle_seq_pkg.sv
source/lane_char_if.sv
source/tx_char_decode.sv
source/idle_seq_gen.sv
source/tx_code_select.sv
source/xaui_tx_lane.sv
testbench/tb_xaui_tx_lane.sv

/* Bender.yml */
package:
  name: xaui_tx_lane

sources:
  - source/line_code_pkg.sv
  - source/idle_seq_pkg.sv
  - source/lane_char_if.sv
  - source/tx_char_decode.sv
  - source/idle_seq_gen.sv
  - source/tx_code_select.sv
  - source/xaui_tx_lane.sv
  - target: simulation
    files:
      - testbench/tb_xaui_tx_lane.sv
